// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= exec_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Test OK" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
rtl/exec_pkg.sv
rtl/instr_queue.sv
rtl/exec_ctrl.sv
rtl/credit_counter.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/exec_top.sv
test/exec_properties.sv
test/exec_tb.sv

// ==== rtl/alu.sv ====
//////////////////////////////
// Flags come from the current operands; shift counts use all of in2
//////////////////////////////
`timescale 1ns/1ps

module alu import exec_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             en,
  input  logic [WIDTH-1:0] in1,
  input  logic [WIDTH-1:0] in2,
  input  alufunc_t         func,
  output logic [WIDTH-1:0] result,
  output logic [3:0]       ccr
);

  logic [WIDTH-1:0] res_next;
  logic             c_next;
  logic             v_next;
  logic [WIDTH:0]   wide;
  logic             s1;
  logic             s2;

  assign s1 = in1[WIDTH-1];
  assign s2 = in2[WIDTH-1];

  //////////////////////////////
  // Next result and flags
  //////////////////////////////
  always_comb
  begin
    res_next = '0;
    c_next   = 1'b0;
    v_next   = 1'b0;
    wide     = '0;
    case (func)
      ALU_AND: res_next = in1 & in2;
      ALU_OR:  res_next = in1 | in2;
      ALU_XOR: res_next = in1 ^ in2;
      ALU_ADD:
      begin
        wide     = {1'b0, in1} + {1'b0, in2};
        res_next = wide[WIDTH-1:0];
        c_next   = wide[WIDTH];                     // Carry out of bit 31
        v_next   = (s1 == s2) && (res_next[WIDTH-1] != s1);
      end
      ALU_SUB:
      begin
        res_next = in1 - in2;
        c_next   = (in1 < in2);                     // Borrow
        v_next   = (s1 != s2) && (res_next[WIDTH-1] != s1);
      end
      ALU_LSHIFT:
      begin
        wide     = {1'b0, in1} << in2;
        res_next = wide[WIDTH-1:0];
        c_next   = wide[WIDTH];
        v_next   = res_next[WIDTH-1] ^ c_next;
      end
      ALU_RSHIFTA:
      begin
        res_next = $signed(in1) >>> in2;            // Sign fill, even past 31
        v_next   = res_next[WIDTH-1];
      end
      ALU_RSHIFTL:
      begin
        res_next = in1 >> in2;
        v_next   = res_next[WIDTH-1];
      end
      default: res_next = '0;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
    begin
      result <= '0;
      ccr    <= '0;
    end
    else if (en)
    begin
      result <= res_next;
      ccr    <= {c_next, ~|res_next, res_next[WIDTH-1], v_next};   // {c, z, n, v}
    end

endmodule

// ==== rtl/credit_counter.sv ====
//////////////////////////////
// Returns never exceed the credits spent
//////////////////////////////
`timescale 1ns/1ps

module credit_counter import exec_pkg::*;
(
  input  logic clk_i,
  input  logic rst_i,
  input  logic send,
  input  logic credit_ret,
  output logic credit_avail
);

  logic [RES_CW-1:0] cnt;

  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      cnt <= RES_CW'(RES_CREDITS);
    else
    begin
      case ({send, credit_ret})
        2'b10:   cnt <= cnt - 1'b1;                 // Result spends a credit
        2'b01:   cnt <= cnt + 1'b1;
        default: cnt <= cnt;                        // Both or neither, no change
      endcase
    end

  assign credit_avail = (cnt != '0);

endmodule

// ==== rtl/exec_ctrl.sv ====
//////////////////////////////
// One instruction in flight, at most one issue every 3 cycles
//////////////////////////////
`timescale 1ns/1ps

module exec_ctrl import exec_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              empty,
  input  instr_u            head,
  input  logic              credit_avail,
  output logic              pop,
  output logic [REG_AW-1:0] ra_addr,
  output logic [REG_AW-1:0] rb_addr,
  output logic              imm_sel,
  output logic [WIDTH-1:0]  imm_val,
  output alufunc_t          func,
  output logic              alu_en,
  output logic              wr_en,
  output logic [REG_AW-1:0] wr_addr,
  output logic              send
);

  logic [1:0] state_q;
  logic [1:0] state_d;
  instr_u     ir;                                   // Latched instruction

  // A downstream credit is reserved at issue, so WB can always send
  assign pop = (state_q == ST_IDLE) && !empty && credit_avail;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (pop) state_d = ST_EXEC;
      ST_EXEC: state_d = ST_WB;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      state_q <= ST_IDLE;
    else
      state_q <= state_d;

  always_ff @(posedge clk_i)
    if (pop)
      ir <= head;

  //////////////////////////////
  // Decode
  //////////////////////////////
  assign imm_sel = ir.r.fmt;
  assign func    = ir.r.func;
  assign ra_addr = ir.r.ra;
  assign rb_addr = ir.r.fmt ? '0 : ir.r.rb;         // No second read in immediate form
  assign imm_val = {{(WIDTH - 20){ir.i.imm20[19]}}, ir.i.imm20};
  assign wr_addr = ir.r.rd;

  assign alu_en = (state_q == ST_EXEC);
  assign send   = (state_q == ST_WB);
  assign wr_en  = send && (ir.r.rd != '0);          // r0 stays zero

endmodule

// ==== rtl/exec_pkg.sv ====
//////////////////////////////
// Shared widths, depths, ALU function codes and the instruction word
// IQ_DEPTH must be a power of two
//////////////////////////////
package exec_pkg;

  localparam int WIDTH  = 32;
  localparam int NREGS  = 16;
  localparam int REG_AW = 4;

  localparam int IQ_DEPTH = 4;                       // Also the sender's credits after reset
  localparam int IQ_AW    = $clog2(IQ_DEPTH);
  localparam int IQ_CW    = $clog2(IQ_DEPTH + 1);

  localparam int RES_CREDITS = 2;
  localparam int RES_CW      = $clog2(RES_CREDITS + 1);

  // Controller state encodings
  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_EXEC = 2'd1;
  localparam logic [1:0] ST_WB   = 2'd2;

  typedef enum logic [2:0] {
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_ADD,
    ALU_SUB,
    ALU_LSHIFT,
    ALU_RSHIFTA,
    ALU_RSHIFTL
  } alufunc_t;

  //////////////////////////////
  // Instruction word, fmt picks the view
  //////////////////////////////
  typedef union packed {
    struct packed {
      logic              fmt;                       // 0 for register form
      alufunc_t          func;
      logic [REG_AW-1:0] rd;
      logic [REG_AW-1:0] ra;
      logic [REG_AW-1:0] rb;
      logic [15:0]       unused;
    } r;
    struct packed {
      logic              fmt;                       // 1 for immediate form
      alufunc_t          func;
      logic [REG_AW-1:0] rd;
      logic [REG_AW-1:0] ra;
      logic [19:0]       imm20;                     // Sign-extended to WIDTH
    } i;
  } instr_u;

endpackage

// ==== rtl/exec_top.sv ====
//////////////////////////////
// Credit-based on both sides; results leave in issue order
//////////////////////////////
`timescale 1ns/1ps

module exec_top import exec_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             instr_valid,
  input  logic [WIDTH-1:0] instr_data,
  output logic             instr_credit,
  output logic             res_valid,
  output logic [WIDTH-1:0] res_data,
  output logic [3:0]       res_ccr,
  input  logic             res_credit
);

  instr_u            head;
  logic              empty;
  logic              pop;
  logic              credit_avail;
  logic              send;
  logic [REG_AW-1:0] ra_addr;
  logic [REG_AW-1:0] rb_addr;
  logic [REG_AW-1:0] wr_addr;
  logic              imm_sel;
  logic [WIDTH-1:0]  imm_val;
  logic [WIDTH-1:0]  ra_data;
  logic [WIDTH-1:0]  rb_data;
  logic [WIDTH-1:0]  alu_in2;
  alufunc_t          func;
  logic              alu_en;
  logic              wr_en;

  instr_queue u_queue (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .push         (instr_valid),
    .push_data    (instr_data),
    .pop          (pop),
    .head         (head),
    .empty        (empty),
    .instr_credit (instr_credit)
  );

  exec_ctrl u_ctrl (
    .clk_i, .rst_i, .empty, .head, .credit_avail, .pop,
    .ra_addr, .rb_addr, .imm_sel, .imm_val, .func,
    .alu_en, .wr_en, .wr_addr, .send
  );

  credit_counter u_credits (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .send         (send),
    .credit_ret   (res_credit),
    .credit_avail (credit_avail)
  );

  reg_file u_regs (
    .clk_i, .rst_i, .ra_addr, .rb_addr, .ra_data, .rb_data,
    .wr_en, .wr_addr,
    .wr_data (res_data)                             // ALU output written back in WB
  );

  assign alu_in2 = imm_sel ? imm_val : rb_data;

  alu u_alu (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .en     (alu_en),
    .in1    (ra_data),
    .in2    (alu_in2),
    .func   (func),
    .result (res_data),
    .ccr    (res_ccr)
  );

  assign res_valid = send;

endmodule

// ==== rtl/instr_queue.sv ====
//////////////////////////////
// Relies on the sender's credits to never push when full
//////////////////////////////
`timescale 1ns/1ps

module instr_queue import exec_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   push,
  input  instr_u push_data,
  input  logic   pop,
  output instr_u head,
  output logic   empty,
  output logic   instr_credit
);

  instr_u           mem [IQ_DEPTH];
  logic [IQ_AW-1:0] wr_ptr;
  logic [IQ_AW-1:0] rd_ptr;
  logic [IQ_CW-1:0] count;
  logic             full;
  logic             do_push;

  assign full    = (count == IQ_CW'(IQ_DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign head    = mem[rd_ptr];

  always_ff @(posedge clk_i)
    if (do_push)
      mem[wr_ptr] <= push_data;

  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
    begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      instr_credit <= 1'b0;
    end
    else
    begin
      instr_credit <= pop;                          // One credit back per pop
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;                    // Wraps at IQ_DEPTH
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end

endmodule

// ==== rtl/reg_file.sv ====
//////////////////////////////
// Reads are combinational, r0 is never written
//////////////////////////////
`timescale 1ns/1ps

module reg_file import exec_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic [REG_AW-1:0] ra_addr,
  input  logic [REG_AW-1:0] rb_addr,
  output logic [WIDTH-1:0]  ra_data,
  output logic [WIDTH-1:0]  rb_data,
  input  logic              wr_en,
  input  logic [REG_AW-1:0] wr_addr,
  input  logic [WIDTH-1:0]  wr_data
);

  logic [WIDTH-1:0] regs [NREGS];

  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
    begin
      for (int k = 0; k < NREGS; k++)
        regs[k] <= '0;
    end
    else if (wr_en && (wr_addr != '0))
      regs[wr_addr] <= wr_data;

  // Written in WB, so visible to the next EXEC
  assign ra_data = regs[ra_addr];
  assign rb_data = regs[rb_addr];

endmodule

// ==== test/exec_properties.sv ====
//////////////////////////////
// Bound to exec_top; queue occupancy is tracked here from push and pop
//////////////////////////////
`timescale 1ns/1ps

module exec_properties import exec_pkg::*;
(
  input logic clk_i,
  input logic rst_i,
  input logic instr_valid,
  input logic pop,
  input logic instr_credit,
  input logic res_valid,
  input logic credit_avail
);

  logic [IQ_CW-1:0] occ;

  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      occ <= '0;
    else
      occ <= occ + IQ_CW'(instr_valid) - IQ_CW'(pop);

  no_back_to_back: assert property (@(posedge clk_i) disable iff (rst_i)
    res_valid |=> !res_valid)
    else $error("res_valid was high in two consecutive cycles");

  send_needs_credit: assert property (@(posedge clk_i) disable iff (rst_i)
    res_valid |-> credit_avail)
    else $error("res_valid without a downstream credit");

  no_push_when_full: assert property (@(posedge clk_i) disable iff (rst_i)
    instr_valid |-> (occ != IQ_CW'(IQ_DEPTH)))                 // Sender broke the credit rule
    else $error("Instruction pushed into a full queue");

  quiet_after_reset: assert property (@(posedge clk_i)
    $fell(rst_i) |-> (!instr_credit && !res_valid))
    else $error("Output pulse in the first cycle after reset");

endmodule

// ==== test/exec_tb.sv ====
//////////////////////////////
// Drives 2 ns after each rising edge and samples outputs on the falling edge
// The properties module is bound to exec_top from here
//////////////////////////////
`timescale 1ns/1ps

module exec_tb import exec_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam int N_HELD     = 6;
  localparam int N_BURST    = 40;
  localparam int N_INSTR    = 30 + N_HELD + N_BURST;

  logic             clk_i;
  logic             rst_i;
  logic             instr_valid;
  logic [WIDTH-1:0] instr_data;
  logic             instr_credit;
  logic             res_valid;
  logic [WIDTH-1:0] res_data;
  logic [3:0]       res_ccr;
  logic             res_credit;

  integer           seed        = 84235;
  integer           credit_seed = 84235;
  int               granted     = 0;                // instr_credit pulses seen
  int               spent       = 0;                // Instructions sent
  int               results     = 0;
  int               owed        = 0;                // Results not yet credited back
  logic             return_now  = 1'b0;
  logic             withhold    = 1'b0;
  string            test_name   = "reset";
  logic [35:0]      exp_q [$];
  string            name_q [$];
  logic [WIDTH-1:0] model_regs [NREGS];

  exec_top dut_i (
    .clk_i, .rst_i, .instr_valid, .instr_data, .instr_credit,
    .res_valid, .res_data, .res_ccr, .res_credit
  );

  bind exec_top exec_properties u_props (
    .clk_i, .rst_i, .instr_valid, .pop, .instr_credit, .res_valid, .credit_avail
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial
  begin
    #(CLK_PERIOD * (N_INSTR * 3 * 4 + 200));
    stop_with_failure("Watchdog expired before all results arrived");
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "Simulation stopped on the first failure");
  endtask

  task automatic check(input string name, input logic [35:0] expected,
                       input logic [35:0] actual);
    if (expected !== actual)
    begin
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
      stop_with_failure("Values differ");
    end
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////
  function automatic logic [35:0] alu_ref(input alufunc_t fn, input logic [31:0] a,
                                          input logic [31:0] b);
    logic [31:0] r;
    logic [32:0] w;
    logic        c;
    logic        v;
    longint      exact;
    r = '0;
    w = '0;
    c = 1'b0;
    v = 1'b0;
    case (fn)
      ALU_AND: r = a & b;
      ALU_OR:  r = a | b;
      ALU_XOR: r = a ^ b;
      ALU_ADD:
      begin
        w = {1'b0, a} + {1'b0, b};
        r = w[31:0];
        c = w[32];
        exact = longint'($signed(a)) + longint'($signed(b));
        v = (exact != longint'($signed(r)));          // True sum does not fit in 32 bits
      end
      ALU_SUB:
      begin
        r = a - b;
        c = (a < b);
        exact = longint'($signed(a)) - longint'($signed(b));
        v = (exact != longint'($signed(r)));
      end
      ALU_LSHIFT:
      begin
        if (b <= 32)
          w = {1'b0, a} << b[5:0];
        r = w[31:0];
        c = w[32];
        v = r[31] ^ c;
      end
      ALU_RSHIFTA:
      begin
        if (b >= 32)
          r = {32{a[31]}};
        else
          r = $signed(a) >>> b[4:0];
        v = r[31];
      end
      default:
      begin
        if (b < 32)
          r = a >> b[4:0];
        v = r[31];
      end
    endcase
    return {c, (r == 32'd0), r[31], v, r};
  endfunction

  function automatic logic [WIDTH-1:0] reg_instr(alufunc_t fn, int rd, int ra, int rb);
    return {1'b0, fn, 4'(rd), 4'(ra), 4'(rb), 16'h0000};
  endfunction

  function automatic logic [WIDTH-1:0] imm_instr(alufunc_t fn, int rd, int ra, int imm);
    return {1'b1, fn, 4'(rd), 4'(ra), 20'(imm)};
  endfunction

  // Called and returns 2 ns after a rising edge
  task automatic send_instr(input logic [31:0] word);
    logic [3:0]  rd;
    logic [3:0]  ra;
    logic [31:0] in2;
    logic [35:0] expected;
    rd  = word[27:24];
    ra  = word[23:20];
    in2 = word[31] ? {{12{word[19]}}, word[19:0]} : model_regs[word[19:16]];
    expected = alu_ref(alufunc_t'(word[30:28]), model_regs[ra], in2);
    if (rd != 4'd0)
      model_regs[rd] = expected[31:0];
    exp_q.push_back(expected);
    name_q.push_back(test_name);
    while (IQ_DEPTH + granted - spent == 0)
    begin
      @(posedge clk_i);
      #2;
    end
    instr_valid = 1'b1;
    instr_data  = word;
    spent++;
    @(posedge clk_i);
    #2;
    instr_valid = 1'b0;
  endtask

  task automatic drain();
    while (results != exp_q.size() || owed != 0 || return_now)
    begin
      @(posedge clk_i);
      #2;
    end
    repeat (2) @(posedge clk_i);
    #2;
    check({test_name, " credits back"}, 36'(IQ_DEPTH), 36'(IQ_DEPTH + granted - spent));
  endtask

  // Compare process, also plays the consumer that returns result credits
  always @(negedge clk_i)
  begin
    logic [31:0] draw;
    draw = $random(credit_seed);
    if (!rst_i)
    begin
      if (instr_credit)
        granted++;
      if (res_valid)
      begin
        if (results >= exp_q.size())
          stop_with_failure("A result arrived with no instruction outstanding");
        else
        begin
          check(name_q[results], exp_q[results], {res_ccr, res_data});
          results++;
          owed++;
        end
      end
      return_now = !withhold && (owed > 0) && (draw[1:0] != 2'b00);
      if (return_now)
        owed--;
    end
  end

  initial
  begin
    res_credit = 1'b0;
    forever
    begin
      @(posedge clk_i);
      #2;
      res_credit = return_now;
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial
  begin
    int base_results;
    for (int k = 0; k < NREGS; k++)
      model_regs[k] = '0;
    rst_i       = 1'b1;
    instr_valid = 1'b0;
    instr_data  = '0;
    repeat (3) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
    repeat (5) @(posedge clk_i);
    #2;
    check("reset", 36'd0, 36'(granted + results));

    test_name = "imm_form";
    send_instr(imm_instr(ALU_ADD, 1, 0, 1));
    send_instr(imm_instr(ALU_ADD, 2, 0, -1));           // All ones adds -1
    send_instr(imm_instr(ALU_ADD, 3, 0, 31));
    send_instr(imm_instr(ALU_ADD, 4, 0, 33));
    send_instr(imm_instr(ALU_ADD, 7, 0, 'h12345));
    send_instr(imm_instr(ALU_ADD, 8, 0, 'h80000));      // Becomes 0xfff80000
    send_instr(imm_instr(ALU_RSHIFTL, 5, 2, 1));
    send_instr(imm_instr(ALU_LSHIFT, 6, 1, 31));
    send_instr(imm_instr(ALU_SUB, 9, 7, -1));
    test_name = "reg_form";
    send_instr(reg_instr(ALU_AND, 9, 7, 8));
    send_instr(reg_instr(ALU_OR, 10, 7, 8));
    send_instr(reg_instr(ALU_XOR, 11, 2, 7));
    send_instr(reg_instr(ALU_XOR, 11, 7, 7));
    send_instr(reg_instr(ALU_ADD, 12, 5, 1));           // Signed overflow
    send_instr(reg_instr(ALU_ADD, 12, 2, 1));           // Carry with a zero result
    send_instr(reg_instr(ALU_SUB, 13, 1, 2));
    send_instr(reg_instr(ALU_SUB, 13, 6, 1));
    send_instr(reg_instr(ALU_LSHIFT, 14, 7, 0));
    send_instr(reg_instr(ALU_LSHIFT, 14, 2, 3));
    send_instr(reg_instr(ALU_LSHIFT, 14, 6, 1));
    send_instr(reg_instr(ALU_LSHIFT, 14, 7, 4));
    send_instr(reg_instr(ALU_RSHIFTA, 15, 6, 3));
    send_instr(reg_instr(ALU_RSHIFTA, 15, 8, 4));
    send_instr(reg_instr(ALU_RSHIFTA, 15, 7, 0));
    send_instr(reg_instr(ALU_RSHIFTL, 15, 6, 3));
    send_instr(reg_instr(ALU_RSHIFTL, 15, 2, 4));
    test_name = "r0";
    send_instr(reg_instr(ALU_ADD, 0, 7, 1));
    send_instr(reg_instr(ALU_OR, 10, 0, 0));            // r0 must still read zero
    drain();

    test_name    = "held_credits";
    base_results = results;
    withhold     = 1'b1;
    for (int k = 0; k < N_HELD; k++)
      send_instr(imm_instr(ALU_ADD, 9, 9, k + 1));      // Running sum, so order shows
    repeat (30) @(posedge clk_i);
    #2;
    check("held_credits", 36'(RES_CREDITS), 36'(results - base_results));
    check("held_stall", 36'(IQ_DEPTH), 36'(spent - granted));
    withhold = 1'b0;
    drain();

    test_name = "burst";
    for (int k = 0; k < N_BURST; k++)
      send_instr($random(seed));
    drain();

    $display("Test OK");
    $finish;
  end

endmodule
